/* src/bigMulPkg.sv */
package bigMulPkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////
	localparam int OperandWidth = 256;
	localparam int LimbWidth = 32;
	localparam int NumLimbs = OperandWidth / LimbWidth;
	localparam int ProductWidth = 2 * OperandWidth;

	////////////////////////////////////////////////////////////////////////////
	// Queue depths and credits
	////////////////////////////////////////////////////////////////////////////
	localparam int InQueueDepth = 4;
	localparam int OutQueueDepth = 4;
	localparam int SinkCredits = 2;

	// Wide enough for running credit totals, not only the live counters
	localparam int CreditWidth = 16;

	typedef logic [OperandWidth-1:0] operandT;
	typedef logic [LimbWidth-1:0] limbT;
	typedef logic [ProductWidth-1:0] productT;
	typedef logic [CreditWidth-1:0] creditT;

	// One queue entry on the input side
	typedef struct packed {
		operandT multiplicand;
		operandT multiplier;
	} operandPairT;

endpackage

/* src/queueIf.sv */
`timescale 1ns/1ns

// Push/pop handshake between a queue and its two neighbours
interface queueIf #(
	parameter type payloadT = logic
) ();

	// Producer side
	logic push;
	payloadT pushData;
	logic full;

	// Consumer side
	logic pop;
	payloadT popData;
	logic empty;

	modport producer (
		output push,
		output pushData,
		input full
	);

	modport consumer (
		output pop,
		input popData,
		input empty
	);

	modport queue (
		input push,
		input pushData,
		output full,
		input pop,
		output popData,
		output empty
	);

endinterface

/* src/creditQueue.sv */
`timescale 1ns/1ns

module creditQueue #(
	parameter type payloadT = logic,
	parameter int Depth = 4
) (
	input logic clk,
	input logic rst,
	queueIf.queue q,
	output logic popPulse
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	payloadT mem [Depth];
	logic [PtrWidth-1:0] rdPtr;
	logic [PtrWidth-1:0] wrPtr;
	logic [CountWidth-1:0] count;
	logic doPush;
	logic doPop;

	// Pointer step with wrap, Depth need not be a power of two
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		logic [PtrWidth-1:0] result;
		if (ptr == PtrWidth'(Depth - 1)) begin
			result = '0;
		end else begin
			result = ptr + 1'b1;
		end
		return result;
	endfunction

	assign doPush = q.push && !q.full;
	assign doPop = q.pop && !q.empty;

	assign q.full = (count == CountWidth'(Depth));
	assign q.empty = (count == '0);
	assign q.popData = mem[rdPtr];

	// One pulse per entry leaving, returned upstream as a credit
	assign popPulse = doPop;

	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= q.pushData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doPop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* src/limbSerialMul.sv */
`timescale 1ns/1ns

module limbSerialMul (
	input logic clk,
	input logic rst,
	input logic start,
	input bigMulPkg::operandT multiplier,
	input bigMulPkg::limbT limb,
	output bigMulPkg::productT partial,
	output logic done
);

	import bigMulPkg::*;

	productT shiftReg;
	productT acc;
	limbT limbReg;
	logic [$clog2(LimbWidth)-1:0] bitCnt;
	logic running;

	assign partial = acc;

	// Bit 0 of the limb is handled in the load cycle itself
	always_ff @(posedge clk) begin
		if (start) begin
			acc <= limb[0] ? productT'(multiplier) : '0;
			shiftReg <= productT'(multiplier) << 1;
			limbReg <= limb >> 1;
		end else if (running) begin
			if (limbReg[0]) begin
				acc <= acc + shiftReg;
			end
			shiftReg <= shiftReg << 1;
			limbReg <= limbReg >> 1;
		end
	end

	// Bit counter, done lands LimbWidth cycles after start
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			bitCnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				bitCnt <= 1;
			end else if (running) begin
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == ($clog2(LimbWidth))'(LimbWidth - 1)) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

/* src/partialProductSum.sv */
`timescale 1ns/1ns

module partialProductSum (
	input logic clk,
	input logic rst,
	input logic load,
	input bigMulPkg::productT partials [bigMulPkg::NumLimbs],
	output logic busy,
	queueIf.producer res
);

	import bigMulPkg::*;

	typedef enum logic [1:0] {
		Idle,
		Sum,
		Push
	} stateT;

	stateT state;
	productT held [NumLimbs];
	productT acc;
	logic [$clog2(NumLimbs)-1:0] idx;

	assign busy = (state != Idle);
	assign res.push = (state == Push) && !res.full;
	assign res.pushData = acc;

	////////////////////////////////////////////////////////////////////////////
	// Accumulate one limb offset per cycle
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (load && state == Idle) begin
			held <= partials;
			acc <= '0;
		end else if (state == Sum) begin
			acc <= acc + (held[idx] << (idx * LimbWidth));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
			idx <= '0;
		end else begin
			case (state)
				Idle: begin
					if (load) begin
						state <= Sum;
						idx <= '0;
					end
				end
				Sum: begin
					idx <= idx + 1'b1;
					if (idx == ($clog2(NumLimbs))'(NumLimbs - 1)) begin
						state <= Push;
					end
				end
				// Hold the sum while the result queue is full
				Push: begin
					if (!res.full) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

/* src/mulSequencer.sv */
`timescale 1ns/1ns

module mulSequencer (
	input logic clk,
	input logic rst,
	queueIf.consumer ops,
	input logic busy,
	output bigMulPkg::productT partials [bigMulPkg::NumLimbs],
	output logic load
);

	import bigMulPkg::*;

	typedef enum logic [1:0] {
		Idle,
		Run,
		Hold
	} stateT;

	stateT state;
	operandPairT pair;
	logic start;
	logic [NumLimbs-1:0] limbDone;
	logic allDone;

	assign pair = ops.popData;

	// Pop and start in the same cycle
	assign start = (state == Idle) && !ops.empty;
	assign ops.pop = start;

	assign allDone = &limbDone;
	assign load = ((state == Run && allDone) || state == Hold) && !busy;

	////////////////////////////////////////////////////////////////////////////
	// One serial multiplier per multiplicand limb
	////////////////////////////////////////////////////////////////////////////
	generate
		for (genvar i = 0; i < NumLimbs; i++) begin : gLimb
			limbSerialMul u_limbMul (
				.clk(clk),
				.rst(rst),
				.start(start),
				.multiplier(pair.multiplier),
				.limb(pair.multiplicand[i*LimbWidth +: LimbWidth]),
				.partial(partials[i]),
				.done(limbDone[i])
			);
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
		end else begin
			case (state)
				Idle: begin
					if (start) begin
						state <= Run;
					end
				end
				Run: begin
					if (allDone) begin
						// Summing stage still on the previous pair
						state <= busy ? Hold : Idle;
					end
				end
				Hold: begin
					if (!busy) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

/* src/resultIssue.sv */
`timescale 1ns/1ns

module resultIssue (
	input logic clk,
	input logic rst,
	queueIf.consumer res,
	input logic outCredit,
	output logic outValid,
	output bigMulPkg::productT outProduct
);

	import bigMulPkg::*;

	creditT credits;
	logic send;

	// Send only against a credit held from the sink
	assign send = !res.empty && (credits != '0);
	assign res.pop = send;

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= creditT'(SinkCredits);
			outValid <= 1'b0;
		end else begin
			credits <= credits + creditT'(outCredit) - creditT'(send);
			outValid <= send;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			outProduct <= res.popData;
		end
	end

endmodule

/* src/bigMulTop.sv */
`timescale 1ns/1ns

module bigMulTop (
	input logic clk,
	input logic rst,
	input logic inValid,
	input bigMulPkg::operandT inA,
	input bigMulPkg::operandT inB,
	output logic inCredit,
	output logic outValid,
	output bigMulPkg::productT outProduct,
	input logic outCredit
);

	import bigMulPkg::*;

	queueIf #(.payloadT(operandPairT)) opQueueBus ();
	queueIf #(.payloadT(productT)) resQueueBus ();

	productT partials [NumLimbs];
	logic sumBusy;
	logic sumLoad;

	// Upstream never pushes without a credit, so full is not checked here
	assign opQueueBus.push = inValid;
	assign opQueueBus.pushData = '{multiplicand: inA, multiplier: inB};

	////////////////////////////////////////////////////////////////////////////
	// Input queue, limb multipliers, summing stage, result queue
	////////////////////////////////////////////////////////////////////////////
	creditQueue #(
		.payloadT(operandPairT),
		.Depth(InQueueDepth)
	) u_opQueue (
		.clk(clk),
		.rst(rst),
		.q(opQueueBus.queue),
		.popPulse(inCredit)
	);

	mulSequencer u_mulSequencer (
		.clk(clk),
		.rst(rst),
		.ops(opQueueBus.consumer),
		.busy(sumBusy),
		.partials(partials),
		.load(sumLoad)
	);

	partialProductSum u_partialProductSum (
		.clk(clk),
		.rst(rst),
		.load(sumLoad),
		.partials(partials),
		.busy(sumBusy),
		.res(resQueueBus.producer)
	);

	creditQueue #(
		.payloadT(productT),
		.Depth(OutQueueDepth)
	) u_resQueue (
		.clk(clk),
		.rst(rst),
		.q(resQueueBus.queue),
		.popPulse()
	);

	resultIssue u_resultIssue (
		.clk(clk),
		.rst(rst),
		.res(resQueueBus.consumer),
		.outCredit(outCredit),
		.outValid(outValid),
		.outProduct(outProduct)
	);

endmodule

/* tests/bigMulTopTb.sv */
`timescale 1ns/1ns

module bigMulTopTb;

	import bigMulPkg::*;

	localparam int CreditTimeout = 2000;
	localparam int DrainTimeout = 20000;
	localparam int NumRandom = 40;

	logic clk;
	logic rst;
	logic inValid;
	operandT inA;
	operandT inB;
	logic inCredit;
	logic outValid;
	productT outProduct;
	logic outCredit;

	// Expected products in send order
	productT expQ [$];
	logic [31:0] stimState;
	int sentCount;
	int inCreditTotal;
	int outValidTotal;
	int outCreditTotal;
	int peakInFlight;
	int maxDelay;
	bit anySent;
	bit timedOut;
	int productErrors;
	int creditErrors;
	int countErrors;
	int otherErrors;

	bigMulTop u_bigMulTop (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inA(inA),
		.inB(inB),
		.inCredit(inCredit),
		.outValid(outValid),
		.outProduct(outProduct),
		.outCredit(outCredit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Random numbers and reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextWord();
		stimState = xorshift(stimState);
		return stimState;
	endfunction

	function automatic operandT randomOperand();
		operandT value;
		value = '0;
		for (int i = 0; i < NumLimbs; i++) begin
			value[i*LimbWidth +: LimbWidth] = nextWord();
		end
		return value;
	endfunction

	// Schoolbook product, every limb of a against every limb of b
	function automatic productT refMul(input operandT a, input operandT b);
		productT sum;
		logic [63:0] part;
		sum = '0;
		for (int i = 0; i < NumLimbs; i++) begin
			for (int j = 0; j < NumLimbs; j++) begin
				part = 64'(a[i*LimbWidth +: LimbWidth]) * 64'(b[j*LimbWidth +: LimbWidth]);
				sum = sum + (productT'(part) << ((i + j) * LimbWidth));
			end
		end
		return sum;
	endfunction

	function automatic int availableCredits();
		return InQueueDepth + inCreditTotal - sentCount;
	endfunction

	task automatic checkProduct(input productT actual, input productT expected, input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
			productErrors++;
		end
	endtask

	task automatic checkCount(input creditT actual, input creditT expected, input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			countErrors++;
		end
	endtask

	// Upstream side, spends one credit per pair
	task automatic sendPair(input operandT a, input operandT b);
		int waited;
		waited = 0;
		if (!timedOut) begin
			@(posedge clk);
			while (availableCredits() <= 0 && waited < CreditTimeout) begin
				inValid <= 1'b0;
				@(posedge clk);
				waited++;
			end
			if (availableCredits() <= 0) begin
				$display("Timed out at %0t waiting for an input credit", $time);
				timedOut = 1'b1;
				inValid <= 1'b0;
			end else begin
				inValid <= 1'b1;
				inA <= a;
				inB <= b;
				expQ.push_back(refMul(a, b));
				sentCount++;
				anySent = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitor and compare, sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (!rst) begin
			if (!anySent && (inCredit || outValid)) begin
				$display("Output went high at %0t before any pair was sent", $time);
				otherErrors++;
			end
			if (inCredit) begin
				inCreditTotal++;
			end
			if (availableCredits() < 0 || availableCredits() > InQueueDepth) begin
				$display("CHECK FAILED at %0t: upstream credit count %0d out of range",
					$time, availableCredits());
				creditErrors++;
			end
			if (outValid) begin
				if (outValidTotal >= expQ.size()) begin
					$display("Unexpected product at %0t with nothing outstanding", $time);
					otherErrors++;
				end else begin
					checkProduct(outProduct, expQ[outValidTotal], "product");
				end
				outValidTotal++;
				if (outValidTotal > SinkCredits + outCreditTotal) begin
					$display("CHECK FAILED at %0t: %0d products sent against %0d credits",
						$time, outValidTotal, SinkCredits + outCreditTotal);
					creditErrors++;
				end
			end
			// Pairs taken from the input queue but not yet sent out
			if (inCreditTotal - outValidTotal > peakInFlight) begin
				peakInFlight = inCreditTotal - outValidTotal;
			end
		end
	end

	// Consumer frees one product after a random delay
	initial begin
		int delayLeft;
		logic [31:0] rng;
		outCredit = 1'b0;
		delayLeft = 0;
		rng = 32'd1;
		forever begin
			@(posedge clk);
			outCredit <= 1'b0;
			if (!rst && outValidTotal > outCreditTotal) begin
				if (delayLeft == 0) begin
					outCredit <= 1'b1;
					outCreditTotal++;
					rng = xorshift(rng);
					delayLeft = int'(rng % 32'(maxDelay));
				end else begin
					delayLeft--;
				end
			end
		end
	end

	initial begin
		operandT allOnes;
		operandT oneLimb;
		int waited;
		rst = 1'b1;
		inValid = 1'b0;
		inA = '0;
		inB = '0;
		stimState = 32'd1;
		maxDelay = 1;
		allOnes = '1;
		oneLimb = operandT'(32'hA5C3_0F17) << (3 * LimbWidth);
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// Idle outputs after reset
		repeat (5) @(posedge clk);

		// Corner operands
		sendPair('0, randomOperand());
		sendPair(operandT'(1), randomOperand());
		sendPair(randomOperand(), operandT'(1));
		sendPair(allOnes, allOnes);
		sendPair(oneLimb, randomOperand());
		sendPair(oneLimb, allOnes);

		// Random pairs, long consumer delays in the second half fill both queues
		maxDelay = 4;
		for (int n = 0; n < NumRandom; n++) begin
			if (n == NumRandom / 2) begin
				maxDelay = 128;
			end
			sendPair(randomOperand(), randomOperand());
		end
		@(posedge clk);
		inValid <= 1'b0;

		waited = 0;
		while (!timedOut && outValidTotal < sentCount && waited < DrainTimeout) begin
			@(posedge clk);
			waited++;
		end
		if (!timedOut && outValidTotal < sentCount) begin
			$display("Timed out at %0t with %0d of %0d products received",
				$time, outValidTotal, sentCount);
			timedOut = 1'b1;
		end
		repeat (5) @(posedge clk);

		checkCount(creditT'(inCreditTotal), creditT'(sentCount), "input credit pulses");
		checkCount(creditT'(outValidTotal), creditT'(sentCount), "products received");
		// Two products in the engine plus a full result queue
		checkCount(creditT'(peakInFlight), creditT'(OutQueueDepth + 2),
			"peak products in flight");

		$display("Errors: product %0d, credit %0d, count %0d, other %0d, timeout %0d",
			productErrors, creditErrors, countErrors, otherErrors, timedOut);
		if (productErrors + creditErrors + countErrors + otherErrors == 0 && !timedOut) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* bigMulTop.f */
src/bigMulPkg.sv
src/queueIf.sv
src/creditQueue.sv
src/limbSerialMul.sv
src/partialProductSum.sv
src/mulSequencer.sv
src/resultIssue.sv
src/bigMulTop.sv
tests/bigMulTopTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal \
	--top-module bigMulTopTb \
	--Mdir obj_dir \
	-f bigMulTop.f

output=$(./obj_dir/VbigMulTopTb)
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"; then
	exit 0
else
	exit 1
fi
